// File: adderTree.sv
`timescale 1ns/1ps
`default_nettype none

module adderTree import ppsFiltPkg::*; #(
	parameter int NUM_TAPS = 21,
	localparam int HALF_TAPS = (NUM_TAPS + 1) / 2
) (
	input wire sys_clk,
	input wire reset,
	input wire sampleEn,
	input wire sampleT folded [HALF_TAPS],
	output sampleT y
);

	localparam int TREE_LEVELS = $clog2(HALF_TAPS);

	// number of partial sums entering a level
	function automatic int levelWidth(int lvl);
		int w;
		w = HALF_TAPS;
		for (int k = 0; k < lvl; k++) begin
			w = (w + 1) / 2;
		end
		return w;
	endfunction

	sampleT sumQ [TREE_LEVELS][HALF_TAPS];

	for (genvar l = 0; l < TREE_LEVELS; l++) begin : gLevel
		localparam int IN_W = levelWidth(l);
		localparam int OUT_W = levelWidth(l + 1);

		sampleT src [HALF_TAPS];

		if (l == 0) begin : gFirst
			assign src = folded;
		end else begin : gNext
			assign src = sumQ[l-1];
		end

		// slots beyond OUT_W stay at their reset zero
		always_ff @(posedge sys_clk) begin
			if (reset) begin
				sumQ[l] <= '{default: '0};
			end else if (sampleEn) begin
				for (int j = 0; j < IN_W / 2; j++) begin
					sumQ[l][j] <= src[2*j] + src[2*j+1];
				end
				// odd leftover rides along unchanged
				if (IN_W % 2 == 1) begin
					sumQ[l][OUT_W-1] <= src[IN_W-1];
				end
			end
		end
	end

	assign y = sumQ[TREE_LEVELS-1][0];

	// whole pipeline freezes between strobes
	yHoldsWithoutStrobe: assert property (
		@(posedge sys_clk) disable iff (reset)
		!sampleEn |=> $stable(y)
	) else $error("y changed without a sample strobe");

endmodule

`default_nettype wire

// File: ppsFiltPkg.sv
`default_nettype none

package ppsFiltPkg;

	// datapath word for coefficients, products, sums and output
	localparam int SAMPLE_W = 18;

	// APB byte address, one 32-bit word per coefficient
	localparam int APB_ADDR_W = 8;

	typedef logic signed [SAMPLE_W-1:0] sampleT;

	// PAM-4 symbol levels
	typedef enum logic [1:0] {
		LVL_M3 = 2'd0,
		LVL_M1 = 2'd1,
		LVL_P1 = 2'd2,
		LVL_P3 = 2'd3
	} levelT;

	// active clear marks a zero-stuffed sample
	typedef struct packed {
		logic  active;
		levelT level;
	} tapSymT;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		sampleT                pwdata;
	} apbReqT;

	typedef struct packed {
		sampleT prdata;
		logic   pready;
		logic   pslverr;
	} apbRspT;

endpackage

`default_nettype wire

// File: ppsFiltTbTasks.svh
`ifndef PPS_FILT_TB_TASKS_SVH
`define PPS_FILT_TB_TASKS_SVH

task automatic checkSample(input string name, input sampleT expected, input sampleT actual);
	if (actual !== expected) begin
		$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
		$display("TEST RESULT: FAIL");
		$fatal(1, "value mismatch on %s", name);
	end
endtask

task automatic checkBit(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("** Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
		$display("TEST RESULT: FAIL");
		$fatal(1, "value mismatch on %s", name);
	end
endtask

// setup phase, then access phase with the response sampled mid-cycle
task automatic apbWrite(input int idx, input sampleT data, input logic expErr);
	apbReq.psel = 1'b1;
	apbReq.penable = 1'b0;
	apbReq.pwrite = 1'b1;
	apbReq.paddr = APB_ADDR_W'(idx * 4);
	apbReq.pwdata = data;
	nextCycle();
	apbReq.penable = 1'b1;
	#10;
	checkBit("pready", 1'b1, apbRsp.pready);
	checkBit("pslverr", expErr, apbRsp.pslverr);
	nextCycle();
	apbReq = '0;
endtask

task automatic apbRead(input int idx, input sampleT expData, input logic expErr);
	apbReq.psel = 1'b1;
	apbReq.penable = 1'b0;
	apbReq.pwrite = 1'b0;
	apbReq.paddr = APB_ADDR_W'(idx * 4);
	apbReq.pwdata = '0;
	nextCycle();
	apbReq.penable = 1'b1;
	#10;
	checkBit("pready", 1'b1, apbRsp.pready);
	checkBit("pslverr", expErr, apbRsp.pslverr);
	checkSample("prdata", expData, apbRsp.prdata);
	nextCycle();
	apbReq = '0;
endtask

`endif

// File: ppsFiltTb.sv
`timescale 1ns/1ps
`default_nettype none

module ppsFiltTb import ppsFiltPkg::*; ;

	localparam int NUM_TAPS = 21;
	localparam int HALF_TAPS = (NUM_TAPS + 1) / 2;
	localparam int TREE_LEVELS = $clog2(HALF_TAPS);
	localparam int LATENCY = 1 + TREE_LEVELS;
	localparam int RANDOM_STROBES = 400;

	// planned cycles per test, gaps counted at their longest
	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES = 20;
	localparam int APB_CYCLES = 2 * (3 * HALF_TAPS + 8);
	localparam int IMPULSE_CYCLES = 3 * (1 + NUM_TAPS + TREE_LEVELS);
	localparam int RANDOM_CYCLES = RANDOM_STROBES * 4;
	localparam int WRAP_CYCLES = 2 * HALF_TAPS + NUM_TAPS + LATENCY;
	localparam int PLAN_CYCLES = RESET_CYCLES + 2 * IDLE_CYCLES + APB_CYCLES
		+ IMPULSE_CYCLES + RANDOM_CYCLES + WRAP_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * PLAN_CYCLES;

	logic sys_clk = 1'b0;
	logic reset;
	logic sampleEn;
	tapSymT symbol;
	apbReqT apbReq;
	apbRspT apbRsp;
	sampleT y;

	// reference model state
	sampleT coefModel [HALF_TAPS];
	tapSymT shadowTaps [NUM_TAPS];
	sampleT expectQ [$];
	sampleT lastY;
	int cycleCount = 0;

	ppsFiltTop #(
		.NUM_TAPS(NUM_TAPS)
	) i_ppsFiltTop (
		.sys_clk(sys_clk),
		.reset(reset),
		.sampleEn(sampleEn),
		.symbol(symbol),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.y(y)
	);

	always #20 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout: run exceeded %0d clock cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$fatal(1, "simulation did not finish in time");
		end
	end

	task automatic nextCycle();
		@(posedge sys_clk);
		#2;
	endtask

	`include "ppsFiltTbTasks.svh"

	function automatic int levelScale(levelT lvl);
		case (lvl)
			LVL_M3: return -3;
			LVL_M1: return -1;
			LVL_P1: return 1;
			default: return 3;
		endcase
	endfunction

	function automatic int mirrorIdx(int tap);
		return (tap < HALF_TAPS) ? tap : NUM_TAPS - 1 - tap;
	endfunction

	function automatic tapSymT makeSymbol(logic act, levelT lvl);
		tapSymT s;
		s.active = act;
		s.level = lvl;
		return s;
	endfunction

	function automatic tapSymT randSymbol();
		return makeSymbol(1'($urandom_range(1, 0)), levelT'($urandom_range(3, 0)));
	endfunction

	// exact sum cut to 18 bits is the wrapped hardware sum
	function automatic sampleT foldSum();
		int acc;
		acc = 0;
		for (int i = 0; i < NUM_TAPS; i++) begin
			if (shadowTaps[i].active) begin
				acc += levelScale(shadowTaps[i].level) * int'(coefModel[mirrorIdx(i)]);
			end
		end
		return sampleT'(acc);
	endfunction

	// one strobe; expectQ holds one pending result per tree level
	task automatic strobeSample(input tapSymT s);
		sampleT expected;
		symbol = s;
		sampleEn = 1'b1;
		nextCycle();
		sampleEn = 1'b0;
		expected = expectQ.pop_front();
		checkSample("y", expected, y);
		lastY = expected;
		// fold stage took the old taps with the coefficients of this edge
		expectQ.push_back(foldSum());
		for (int i = NUM_TAPS - 1; i > 0; i--) begin
			shadowTaps[i] = shadowTaps[i-1];
		end
		shadowTaps[0] = s;
	endtask

	task automatic impulseTest(input levelT lvl, input int scale);
		int tap;
		strobeSample(makeSymbol(1'b1, lvl));
		for (int n = 1; n <= NUM_TAPS + TREE_LEVELS; n++) begin
			strobeSample(makeSymbol(1'b0, lvl));
			tap = n - LATENCY;
			if (tap >= 0) begin
				checkSample("y impulse", sampleT'(scale * int'(coefModel[mirrorIdx(tap)])), y);
			end
		end
	endtask

	initial begin
		sampleT data;
		int badIdx;
		int gap;
		int offset;
		int acc;
		void'($urandom(32'h1843_57a1));
		reset = 1'b1;
		sampleEn = 1'b0;
		symbol = '0;
		apbReq = '0;
		for (int i = 0; i < HALF_TAPS; i++) begin
			coefModel[i] = '0;
		end
		for (int i = 0; i < NUM_TAPS; i++) begin
			shadowTaps[i] = '0;
		end
		repeat (TREE_LEVELS) expectQ.push_back('0);
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#2;
		reset = 1'b0;

		// quiet after reset, with and without strobes
		checkSample("y", '0, y);
		checkBit("pslverr", 1'b0, apbRsp.pslverr);
		repeat (IDLE_CYCLES) begin
			nextCycle();
			checkSample("y", '0, y);
		end
		repeat (IDLE_CYCLES) strobeSample(makeSymbol(1'b0, LVL_P3));

		// coefficient table over APB
		for (int i = 0; i < HALF_TAPS; i++) begin
			data = sampleT'($urandom);
			apbWrite(i, data, 1'b0);
			coefModel[i] = data;
		end
		for (int i = 0; i < HALF_TAPS; i++) begin
			apbRead(i, coefModel[i], 1'b0);
		end
		repeat (4) begin
			badIdx = $urandom_range(63, HALF_TAPS);
			apbWrite(badIdx, sampleT'($urandom), 1'b1);
			apbRead(badIdx, '0, 1'b1);
		end
		for (int i = 0; i < HALF_TAPS; i++) begin
			apbRead(i, coefModel[i], 1'b0);
		end

		impulseTest(LVL_P1, 1);
		impulseTest(LVL_P3, 3);
		impulseTest(LVL_M3, -3);

		// random stream with stalls between strobes
		for (int n = 0; n < RANDOM_STROBES; n++) begin
			strobeSample(randSymbol());
			gap = $urandom_range(3, 1);
			repeat (gap) begin
				nextCycle();
				checkSample("y hold", lastY, y);
			end
		end

		// near full scale, alternating sign
		for (int i = 0; i < HALF_TAPS; i++) begin
			offset = $urandom_range(15, 0);
			data = (i % 2 == 0) ? sampleT'(131071 - offset) : sampleT'(-131072 + offset);
			apbWrite(i, data, 1'b0);
			coefModel[i] = data;
		end
		repeat (NUM_TAPS + LATENCY) strobeSample(makeSymbol(1'b1, LVL_P3));
		acc = 0;
		for (int i = 0; i < HALF_TAPS; i++) begin
			acc += ((i == HALF_TAPS - 1) ? 3 : 6) * int'(coefModel[i]);
		end
		checkSample("y full scale", sampleT'(acc), y);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: ppsFiltTop.sv
`timescale 1ns/1ps
`default_nettype none

module ppsFiltTop import ppsFiltPkg::*; #(
	parameter int NUM_TAPS = 21,
	localparam int HALF_TAPS = (NUM_TAPS + 1) / 2
) (
	input wire sys_clk,
	input wire reset,
	input wire sampleEn,
	input wire tapSymT symbol,
	input wire apbReqT apbReq,
	output apbRspT apbRsp,
	output sampleT y
);

	// folding needs a single center tap
	if (NUM_TAPS < 3 || NUM_TAPS % 2 == 0) begin : gBadNumTaps
		$error("NUM_TAPS must be odd and at least 3");
	end

	sampleT coefTable [HALF_TAPS];
	tapSymT taps [NUM_TAPS];
	sampleT folded [HALF_TAPS];

	tapCoefRegs #(
		.NUM_TAPS(NUM_TAPS)
	) i_tapCoefRegs (
		.sys_clk(sys_clk),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.coefTable(coefTable)
	);

	symbolDelayLine #(
		.NUM_TAPS(NUM_TAPS)
	) i_symbolDelayLine (
		.sys_clk(sys_clk),
		.reset(reset),
		.sampleEn(sampleEn),
		.symbol(symbol),
		.taps(taps)
	);

	// y lags the taps by 1 + log2 levels of strobes
	symFoldMap #(
		.NUM_TAPS(NUM_TAPS)
	) i_symFoldMap (
		.sys_clk(sys_clk),
		.reset(reset),
		.sampleEn(sampleEn),
		.taps(taps),
		.coefTable(coefTable),
		.folded(folded)
	);

	adderTree #(
		.NUM_TAPS(NUM_TAPS)
	) i_adderTree (
		.sys_clk(sys_clk),
		.reset(reset),
		.sampleEn(sampleEn),
		.folded(folded),
		.y(y)
	);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the PAM-4 FIR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module ppsFiltTb -o ppsFiltSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/ppsFiltSim)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1

// File: src.f
+incdir+.
ppsFiltPkg.sv
tapCoefRegs.sv
symbolDelayLine.sv
symFoldMap.sv
adderTree.sv
ppsFiltTop.sv
ppsFiltTb.sv

// File: symFoldMap.sv
`timescale 1ns/1ps
`default_nettype none

module symFoldMap import ppsFiltPkg::*; #(
	parameter int NUM_TAPS = 21,
	localparam int HALF_TAPS = (NUM_TAPS + 1) / 2
) (
	input wire sys_clk,
	input wire reset,
	input wire sampleEn,
	input wire tapSymT taps [NUM_TAPS],
	input wire sampleT coefTable [HALF_TAPS],
	output sampleT folded [HALF_TAPS]
);

	sampleT prod [NUM_TAPS];

	// level times coefficient without a multiplier
	function automatic sampleT tapProduct(tapSymT tap, sampleT coef);
		sampleT triple;
		sampleT result;
		triple = coef + (coef <<< 1);
		result = '0;
		if (tap.active) begin
			case (tap.level)
				LVL_M3: result = -triple;
				LVL_M1: result = -coef;
				LVL_P1: result = coef;
				LVL_P3: result = triple;
				default: result = '0;
			endcase
		end
		return result;
	endfunction

	// mirror taps share a coefficient
	for (genvar i = 0; i < NUM_TAPS; i++) begin : gTap
		localparam int COEF_IDX = (i < HALF_TAPS) ? i : NUM_TAPS - 1 - i;

		assign prod[i] = tapProduct(taps[i], coefTable[COEF_IDX]);
	end

	// pre-add mirror pairs, center passes alone
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			folded <= '{default: '0};
		end else if (sampleEn) begin
			for (int i = 0; i < HALF_TAPS - 1; i++) begin
				folded[i] <= prod[i] + prod[NUM_TAPS-1-i];
			end
			folded[HALF_TAPS-1] <= prod[HALF_TAPS-1];
		end
	end

endmodule

`default_nettype wire

// File: symbolDelayLine.sv
`timescale 1ns/1ps
`default_nettype none

module symbolDelayLine import ppsFiltPkg::*; #(
	parameter int NUM_TAPS = 21
) (
	input wire sys_clk,
	input wire reset,
	input wire sampleEn,
	input wire tapSymT symbol,
	output tapSymT taps [NUM_TAPS]
);

	logic activeQ [NUM_TAPS];
	levelT levelQ [NUM_TAPS];

	// active flag of each tap clears on reset
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			activeQ <= '{default: 1'b0};
		end else if (sampleEn) begin
			activeQ[0] <= symbol.active;
			for (int i = 1; i < NUM_TAPS; i++) begin
				activeQ[i] <= activeQ[i-1];
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sampleEn) begin
			levelQ[0] <= symbol.level;
			for (int i = 1; i < NUM_TAPS; i++) begin
				levelQ[i] <= levelQ[i-1];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_TAPS; i++) begin
			taps[i].active = activeQ[i];
			taps[i].level = levelQ[i];
		end
	end

	// source must present a clean symbol whenever it strobes
	symbolKnown: assert property (
		@(posedge sys_clk) disable iff (reset)
		sampleEn |-> !$isunknown(symbol)
	) else $error("unknown symbol bits on sample strobe");

endmodule

`default_nettype wire

// File: tapCoefRegs.sv
`timescale 1ns/1ps
`default_nettype none

module tapCoefRegs import ppsFiltPkg::*; #(
	parameter int NUM_TAPS = 21,
	localparam int HALF_TAPS = (NUM_TAPS + 1) / 2
) (
	input wire sys_clk,
	input wire reset,
	input wire apbReqT apbReq,
	output apbRspT apbRsp,
	output sampleT coefTable [HALF_TAPS]
);

	localparam int IDX_W = (HALF_TAPS > 1) ? $clog2(HALF_TAPS) : 1;

	logic [APB_ADDR_W-3:0] wordIdx;
	logic [IDX_W-1:0] coefIdx;
	logic access;
	logic inRange;

	// byte address to word index, low two bits ignored
	assign wordIdx = apbReq.paddr[APB_ADDR_W-1:2];
	assign coefIdx = wordIdx[IDX_W-1:0];
	assign inRange = (wordIdx < HALF_TAPS);
	assign access = apbReq.psel && apbReq.penable;

	// outer tap first, center coefficient in the last slot
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			coefTable <= '{default: '0};
		end else if (access && apbReq.pwrite && inRange) begin
			coefTable[coefIdx] <= apbReq.pwdata;
		end
	end

	// zero wait states, read data valid in the access phase
	always_comb begin
		apbRsp = '0;
		apbRsp.pready = 1'b1;
		if (access) begin
			if (!inRange) begin
				apbRsp.pslverr = 1'b1;
			end else if (!apbReq.pwrite) begin
				apbRsp.prdata = coefTable[coefIdx];
			end
		end
	end

	// master must never raise penable outside a selected transfer
	penableNeedsPsel: assert property (
		@(posedge sys_clk) disable iff (reset)
		apbReq.penable |-> apbReq.psel
	) else $error("APB penable high without psel");

endmodule

`default_nettype wire
